// ==== compile.f ====
hdl/smc_pkg.sv
hdl/smc_cfg_regs.sv
hdl/smc_ahb_slave.sv
hdl/smc_mem_seq.sv
hdl/smc_top.sv
verification/smc_chk.sv
verification/smc_tb.sv

// ==== verification/smc_tb.sv ====
/* Memory controller testbench
   Random AHB transfers and APB reconfiguration against an SRAM model and a reference model */

module smc_tb import smc_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_XFERS   = 300;
  localparam int WORST_CYC   = 32;   // 16 strobe cycles, overhead, APB share
  localparam int TIMEOUT_NS  = (NUM_XFERS * WORST_CYC + 200) * 10;

  logic        hclk;
  logic        rst;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic        hsel;
  logic        hwrite;
  logic [2:0]  hsize;
  logic [31:0] hwdata;
  logic        hready;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] data_smc;
  logic [31:0] smc_hrdata, prdata, smc_addr, smc_data;
  logic        smc_hready, smc_valid, smc_busy;
  logic [1:0]  smc_hresp;
  logic [3:0]  smc_n_be, smc_n_we;
  logic        smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe;

  logic [31:0] dev_mem [256];        // SRAM device contents
  logic [31:0] ref_mem [256];        // Model copy
  logic        exp_enable, exp_wprot;
  logic [3:0]  exp_rd_wait, exp_wr_wait;
  logic [15:0] exp_err;
  logic [3:0]  exp_n_be;             // Lanes of the access in flight
  logic        exp_write;
  logic        cs_allowed = 1'b0;
  logic [31:0] rng = 32'hdb980bd2;
  int          errors = 0;
  int          xfers = 0;
  int          pulses = 0;
  int          rd_len = 0;
  int          wr_len = 0;

  assign hready = smc_hready;        // Single slave bus

  smc_top u_dut (
    .hclk(hclk), .rst(rst), .haddr(haddr), .htrans(htrans), .hsel(hsel),
    .hwrite(hwrite), .hsize(hsize), .hwdata(hwdata), .hready(hready),
    .smc_hrdata(smc_hrdata), .smc_hready(smc_hready), .smc_hresp(smc_hresp),
    .smc_valid(smc_valid), .smc_busy(smc_busy), .psel(psel), .penable(penable),
    .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
    .data_smc(data_smc), .smc_addr(smc_addr), .smc_data(smc_data),
    .smc_n_be(smc_n_be), .smc_n_cs(smc_n_cs), .smc_n_rd(smc_n_rd),
    .smc_n_wr(smc_n_wr), .smc_n_we(smc_n_we), .smc_n_ext_oe(smc_n_ext_oe)
  );

  initial begin
    hclk = 1'b0;
    forever #5 hclk = ~hclk;
  end

  // ----------------------------------------------------------------------
  // SRAM device model
  // ----------------------------------------------------------------------
  assign data_smc = (!smc_n_cs && !smc_n_rd) ? dev_mem[smc_addr[9:2]] : 32'h0;

  for (genvar i = 0; i < 4; i++) begin : g_lane
    always @(posedge smc_n_we[i]) begin
      if (!rst) dev_mem[smc_addr[9:2]][8*i +: 8] <= smc_data[8*i +: 8]; // Latch on release
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Naturally aligned lanes covered by a transfer
  function automatic logic [3:0] byte_lanes(input logic [2:0] size, input logic [1:0] low);
    logic [3:0] lanes;
    int         nbytes;
    int         first;
    lanes  = 4'b0000;
    nbytes = 1 << size;
    first  = int'(low) & ~(nbytes - 1);
    for (int i = 0; i < 4; i++) begin
      if ((i >= first) && (i < first + nbytes)) begin
        lanes[i] = 1'b1;
      end
    end
    return lanes;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Fail %s got %h expected %h at %0t ns", name, got, exp, $time);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("Error: %s at %0t ns", what, $time);
  endtask

  // ----------------------------------------------------------------------
  // APB accesses, model follows each committed write
  // ----------------------------------------------------------------------
  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    penable = 1'b0;
    @(negedge hclk);
    penable = 1'b1;
    @(negedge hclk);                 // Committed on the edge between
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    case (addr)
      REG_CTRL: begin
        exp_enable = data[0];
        exp_wprot  = data[1];
      end
      REG_TIMING: begin
        exp_rd_wait = data[3:0];
        exp_wr_wait = data[7:4];
      end
      REG_STATUS: exp_err = '0;      // Any value clears
      default: ;
    endcase
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    penable = 1'b0;
    @(negedge hclk);
    data    = prdata;                // Combinational from paddr
    penable = 1'b1;
    @(negedge hclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // New timing, a mode from the rotation, status check and maybe clear
  task automatic reconfigure(input int k);
    logic [31:0] r;
    logic [31:0] rdata;
    rng = xorshift32(rng);
    r   = rng;
    apb_write(REG_TIMING, {24'd0, r[7:0]});
    apb_read(REG_TIMING, rdata);
    if (rdata !== {24'd0, exp_wr_wait, exp_rd_wait}) report_mismatch("prdata", rdata, r[7:0]);
    case (k % 5)
      3:       apb_write(REG_CTRL, 32'h3);   // Write protected
      4:       apb_write(REG_CTRL, 32'h0);   // Disabled
      default: apb_write(REG_CTRL, 32'h1);
    endcase
    apb_read(REG_STATUS, rdata);
    if (rdata !== {16'd0, exp_err}) report_mismatch("prdata", rdata, {16'd0, exp_err});
    if (k % 2 == 1) begin
      apb_write(REG_STATUS, r);
      apb_read(REG_STATUS, rdata);
      if (rdata !== 32'd0) report_mismatch("prdata", rdata, 32'd0);
    end
  endtask

  // ----------------------------------------------------------------------
  // One AHB transfer with its expected response
  // ----------------------------------------------------------------------
  task automatic run_transfer(input logic [31:0] addr, input logic [2:0] size,
                              input logic write, input logic [31:0] wdata);
    logic        ok;
    logic [3:0]  be;
    logic [7:0]  idx;
    logic [31:0] mask;
    ok         = exp_enable && !(write && exp_wprot) && (size <= HSIZE_WORD);
    be         = byte_lanes(size, addr[1:0]);
    idx        = addr[9:2];
    mask       = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    exp_n_be   = ~be;
    exp_write  = write;
    cs_allowed = ok;
    hsel   = 1'b1;
    htrans = HTRANS_NONSEQ;
    haddr  = addr;
    hwrite = write;
    hsize  = size;
    @(negedge hclk);                 // Address phase taken
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    hwdata = wdata;
    if (ok) begin
      if (smc_valid !== 1'b1) report_mismatch("smc_valid", smc_valid, 1'b1);
      if (smc_busy !== 1'b1) report_mismatch("smc_busy", smc_busy, 1'b1);
      if (smc_hready !== 1'b0) report_mismatch("smc_hready", smc_hready, 1'b0);
      while (smc_hready !== 1'b1) @(negedge hclk);  // Watchdog bounds this
      if (smc_hresp !== HRESP_OKAY) report_mismatch("smc_hresp", smc_hresp, HRESP_OKAY);
      if (write) begin
        for (int i = 0; i < 4; i++) begin
          if (be[i]) ref_mem[idx][8*i +: 8] = wdata[8*i +: 8];
        end
      end else if ((smc_hrdata & mask) !== (ref_mem[idx] & mask)) begin
        report_mismatch("smc_hrdata", smc_hrdata & mask, ref_mem[idx] & mask);
      end
    end else begin
      if (exp_err != 16'hffff) exp_err++;   // Saturating
      if (smc_valid !== 1'b0) report_mismatch("smc_valid", smc_valid, 1'b0);
      if (smc_hresp !== HRESP_ERROR) report_mismatch("smc_hresp", smc_hresp, HRESP_ERROR);
      if (smc_hready !== 1'b0) report_mismatch("smc_hready", smc_hready, 1'b0);
      @(negedge hclk);               // Second error cycle
      if (smc_hresp !== HRESP_ERROR) report_mismatch("smc_hresp", smc_hresp, HRESP_ERROR);
      if (smc_hready !== 1'b1) report_mismatch("smc_hready", smc_hready, 1'b1);
    end
    xfers++;
  endtask

  // Strobe widths, lanes and chip select screening
  always @(negedge hclk) begin
    if (!smc_n_rd) begin
      rd_len++;
    end else if (rd_len != 0) begin
      pulses++;
      if (rd_len != exp_rd_wait + 1) report_mismatch("smc_n_rd width", rd_len, exp_rd_wait + 1);
      rd_len = 0;
    end
    if (!smc_n_wr) begin
      wr_len++;
    end else if (wr_len != 0) begin
      pulses++;
      if (wr_len != exp_wr_wait + 1) report_mismatch("smc_n_wr width", wr_len, exp_wr_wait + 1);
      wr_len = 0;
    end
    if (smc_n_cs === 1'b0) begin
      if (!cs_allowed) report_problem("chip select asserted for a rejected access");
      if (smc_busy !== 1'b1) report_mismatch("smc_busy", smc_busy, 1'b1);
      if (smc_n_ext_oe !== !exp_write) report_mismatch("smc_n_ext_oe", smc_n_ext_oe, !exp_write);
      if (smc_n_be !== exp_n_be) report_mismatch("smc_n_be", smc_n_be, exp_n_be);
      if (exp_write && (smc_n_we !== exp_n_be)) report_mismatch("smc_n_we", smc_n_we, exp_n_be);
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
    $display("Regression failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] rdata;
    logic [2:0]  size;
    logic [1:0]  low;
    rst = 1'b1;
    {hsel, hwrite, psel, penable, pwrite} = '0;
    htrans = HTRANS_IDLE;
    {haddr, hwdata, pwdata} = '0;
    hsize = HSIZE_WORD;
    paddr = REG_CTRL;
    for (int i = 0; i < 256; i++) begin
      dev_mem[i] = 32'h9e3779b9 * (i + 1);   // Every word distinct
      ref_mem[i] = dev_mem[i];
    end
    exp_enable  = CTRL_RESET[0];
    exp_wprot   = CTRL_RESET[1];
    exp_rd_wait = RD_WAIT_RESET;
    exp_wr_wait = WR_WAIT_RESET;
    exp_err     = '0;
    repeat (2) @(posedge hclk);
    @(negedge hclk);
    rst = 1'b0;
    // Reset state
    if (smc_hready !== 1'b1) report_mismatch("smc_hready", smc_hready, 1'b1);
    if (smc_hresp !== HRESP_OKAY) report_mismatch("smc_hresp", smc_hresp, HRESP_OKAY);
    if ({smc_valid, smc_busy} !== 2'b00)
      report_mismatch("smc_valid/busy", {smc_valid, smc_busy}, 2'b00);
    if ({smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe} !== 4'hf)
      report_mismatch("smc_n_cs/rd/wr/ext_oe", {smc_n_cs, smc_n_rd, smc_n_wr, smc_n_ext_oe}, 4'hf);
    if (smc_n_we !== 4'hf) report_mismatch("smc_n_we", smc_n_we, 4'hf);
    apb_read(REG_CTRL, rdata);
    if (rdata !== {30'd0, CTRL_RESET}) report_mismatch("prdata", rdata, {30'd0, CTRL_RESET});
    apb_read(REG_TIMING, rdata);
    if (rdata !== {24'd0, WR_WAIT_RESET, RD_WAIT_RESET})
      report_mismatch("prdata", rdata, {24'd0, WR_WAIT_RESET, RD_WAIT_RESET});
    apb_read(REG_STATUS, rdata);
    if (rdata !== 32'd0) report_mismatch("prdata", rdata, 32'd0);
    apb_read(5'h0c, rdata);          // Unmapped
    if (rdata !== 32'd0) report_mismatch("prdata", rdata, 32'd0);

    for (int n = 0; n < NUM_XFERS; n++) begin
      if (n % 20 == 0) reconfigure(n / 20);
      rng = xorshift32(rng);
      r   = rng;
      rng = xorshift32(rng);
      d   = rng;
      if (r[2:0] == 3'd7) size = 3'd3 + {1'b0, r[4:3]};  // Wider than a word
      else size = r[2:0] % 3;
      case (size)
        HSIZE_BYTE: low = r[17:16];
        HSIZE_HALF: low = {r[17], 1'b0};
        default:    low = 2'b00;
      endcase
      run_transfer({22'h180000, r[15:8], low}, size, r[18], d);
    end

    // Device contents against the model, covers protected writes too
    for (int i = 0; i < 256; i++) begin
      if (dev_mem[i] !== ref_mem[i]) report_mismatch($sformatf("dev_mem[%0d]", i),
                                                     dev_mem[i], ref_mem[i]);
    end
    $display("Summary: %0d transfers, %0d strobe pulses, %0d errors", xfers, pulses, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== verification/smc_chk.sv ====
/* Sequencer protocol checker
   Strobe exclusivity, chip select coverage and the req/ack handshake */

module smc_chk (
  input logic       hclk,
  input logic       rst,
  input logic       req,
  input logic       ack,
  input logic       smc_n_cs,
  input logic       smc_n_rd,
  input logic       smc_n_wr,
  input logic [3:0] smc_n_we
);
  timeunit 1ns;
  timeprecision 1ps;

  // Read and write strobes are exclusive
  assert property (@(posedge hclk) disable iff (rst) !(!smc_n_rd && !smc_n_wr))
    else $error("read and write strobes low together");

  // Any strobe only inside chip select
  assert property (@(posedge hclk) disable iff (rst)
    (!smc_n_rd || !smc_n_wr || (smc_n_we != 4'hf)) |-> !smc_n_cs)
    else $error("strobe low without chip select");

  assert property (@(posedge hclk) disable iff (rst) $rose(ack) |-> req)
    else $error("ack raised without a pending req");

  // Second phase of the handshake, req waits for ack
  assert property (@(posedge hclk) disable iff (rst) (req && !ack) |=> req)
    else $error("req dropped before ack");

endmodule

bind smc_mem_seq smc_chk u_chk (
  .hclk     (hclk),
  .rst      (rst),
  .req      (req),
  .ack      (ack),
  .smc_n_cs (smc_n_cs),
  .smc_n_rd (smc_n_rd),
  .smc_n_wr (smc_n_wr),
  .smc_n_we (smc_n_we)
);

// ==== hdl/smc_top.sv ====
/* Static memory controller top level
   AHB front end, memory sequencer and APB registers on one clock */

module smc_top (
  input  logic        hclk,
  input  logic        rst,
  // AHB-Lite
  input  logic [31:0] haddr,
  input  logic [1:0]  htrans,
  input  logic        hsel,
  input  logic        hwrite,
  input  logic [2:0]  hsize,
  input  logic [31:0] hwdata,
  input  logic        hready,
  output logic [31:0] smc_hrdata,
  output logic        smc_hready,
  output logic [1:0]  smc_hresp,
  output logic        smc_valid,
  output logic        smc_busy,
  // APB, sampled on hclk
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [4:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  // External memory
  input  logic [31:0] data_smc,
  output logic [31:0] smc_addr,
  output logic [31:0] smc_data,
  output logic [3:0]  smc_n_be,
  output logic        smc_n_cs,
  output logic        smc_n_rd,
  output logic        smc_n_wr,
  output logic [3:0]  smc_n_we,
  output logic        smc_n_ext_oe
);

  logic        req;
  logic        ack;
  logic        acc_write;
  logic [31:0] acc_addr;
  logic [31:0] acc_wdata;
  logic [3:0]  acc_be;
  logic [31:0] rd_data;
  logic        cfg_enable;
  logic        cfg_wprot;
  logic [3:0]  cfg_rd_wait;
  logic [3:0]  cfg_wr_wait;
  logic        err_pulse;

  smc_ahb_slave u_ahb (
    .hclk       (hclk),
    .rst        (rst),
    .haddr      (haddr),
    .htrans     (htrans),
    .hsel       (hsel),
    .hwrite     (hwrite),
    .hsize      (hsize),
    .hwdata     (hwdata),
    .hready     (hready),
    .cfg_enable (cfg_enable),
    .cfg_wprot  (cfg_wprot),
    .ack        (ack),
    .rd_data    (rd_data),
    .smc_hrdata (smc_hrdata),
    .smc_hready (smc_hready),
    .smc_hresp  (smc_hresp),
    .smc_valid  (smc_valid),
    .smc_busy   (smc_busy),
    .req        (req),
    .acc_write  (acc_write),
    .acc_addr   (acc_addr),
    .acc_wdata  (acc_wdata),
    .acc_be     (acc_be),
    .err_pulse  (err_pulse)
  );

  smc_mem_seq u_seq (
    .hclk         (hclk),
    .rst          (rst),
    .req          (req),
    .acc_write    (acc_write),
    .acc_addr     (acc_addr),
    .acc_wdata    (acc_wdata),
    .acc_be       (acc_be),
    .cfg_rd_wait  (cfg_rd_wait),
    .cfg_wr_wait  (cfg_wr_wait),
    .data_smc     (data_smc),
    .ack          (ack),
    .rd_data      (rd_data),
    .smc_addr     (smc_addr),
    .smc_data     (smc_data),
    .smc_n_be     (smc_n_be),
    .smc_n_cs     (smc_n_cs),
    .smc_n_rd     (smc_n_rd),
    .smc_n_wr     (smc_n_wr),
    .smc_n_we     (smc_n_we),
    .smc_n_ext_oe (smc_n_ext_oe)
  );

  smc_cfg_regs u_cfg (
    .hclk        (hclk),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .err_pulse   (err_pulse),
    .prdata      (prdata),
    .cfg_enable  (cfg_enable),
    .cfg_wprot   (cfg_wprot),
    .cfg_rd_wait (cfg_rd_wait),
    .cfg_wr_wait (cfg_wr_wait)
  );

endmodule

// ==== hdl/smc_mem_seq.sv ====
/* External memory sequencer
   Runs one timed read or write on the asynchronous device per req/ack handshake */

module smc_mem_seq
  import smc_pkg::*;
(
  input  logic        hclk,
  input  logic        rst,
  input  logic        req,
  input  logic        acc_write,
  input  logic [31:0] acc_addr,
  input  logic [31:0] acc_wdata,
  input  logic [3:0]  acc_be,
  input  logic [3:0]  cfg_rd_wait,
  input  logic [3:0]  cfg_wr_wait,
  input  logic [31:0] data_smc,      // From device
  output logic        ack,
  output logic [31:0] rd_data,
  output logic [31:0] smc_addr,
  output logic [31:0] smc_data,
  output logic [3:0]  smc_n_be,
  output logic        smc_n_cs,
  output logic        smc_n_rd,
  output logic        smc_n_wr,
  output logic [3:0]  smc_n_we,
  output logic        smc_n_ext_oe
);

  logic [1:0] state;
  logic [3:0] wait_cnt;   // Strobe cycles left minus one
  logic       start;
  logic       last;

  assign start = (state == SEQ_IDLE) && req;
  assign last  = (state == SEQ_ACCESS) && (wait_cnt == 4'd0);

  // ----------------------------------------------------------------------
  // Strobe timing
  // ----------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      state        <= SEQ_IDLE;
      wait_cnt     <= 4'd0;
      ack          <= 1'b0;
      smc_n_cs     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= 4'hf;
      smc_n_be     <= 4'hf;
      smc_n_ext_oe <= 1'b1;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (req) begin
            state        <= SEQ_ACCESS;
            wait_cnt     <= acc_write ? cfg_wr_wait : cfg_rd_wait;
            smc_n_cs     <= 1'b0;
            smc_n_be     <= ~acc_be;
            smc_n_rd     <= acc_write;
            smc_n_wr     <= !acc_write;
            smc_n_we     <= acc_write ? ~acc_be : 4'hf; // Per-byte write lanes
            smc_n_ext_oe <= !acc_write;                 // Drive bus for writes
          end
        end
        SEQ_ACCESS: begin
          if (last) begin
            // Release everything together, device latches on rising n_we
            smc_n_cs     <= 1'b1;
            smc_n_rd     <= 1'b1;
            smc_n_wr     <= 1'b1;
            smc_n_we     <= 4'hf;
            smc_n_be     <= 4'hf;
            smc_n_ext_oe <= 1'b1;
            ack          <= 1'b1;
            state        <= SEQ_ACK;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        SEQ_ACK: begin
          if (!req) begin
            ack   <= 1'b0;               // Fourth phase
            state <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // Address, write data and read capture
  always_ff @(posedge hclk) begin
    if (start) begin
      smc_addr <= acc_addr;
      smc_data <= acc_wdata;             // Held past n_we release
    end
    if (last && !smc_n_rd) begin
      rd_data <= data_smc;               // Last strobe cycle
    end
  end

endmodule

// ==== hdl/smc_ahb_slave.sv ====
/* AHB-Lite front end of the memory controller
   Captures single transfers, screens them and hands legal ones to the sequencer */

module smc_ahb_slave
  import smc_pkg::*;
(
  input  logic        hclk,
  input  logic        rst,
  input  logic [31:0] haddr,
  input  logic [1:0]  htrans,
  input  logic        hsel,
  input  logic        hwrite,
  input  logic [2:0]  hsize,
  input  logic [31:0] hwdata,
  input  logic        hready,
  input  logic        cfg_enable,
  input  logic        cfg_wprot,
  input  logic        ack,
  input  logic [31:0] rd_data,
  output logic [31:0] smc_hrdata,
  output logic        smc_hready,
  output logic [1:0]  smc_hresp,
  output logic        smc_valid,
  output logic        smc_busy,
  output logic        req,
  output logic        acc_write,
  output logic [31:0] acc_addr,
  output logic [31:0] acc_wdata,
  output logic [3:0]  acc_be,
  output logic        err_pulse
);

  logic [2:0] state;
  logic       addr_valid;   // Address phase taken this edge
  logic       legal;
  logic [3:0] be_dec;

  // Only sampled while our own data phase is not stalled
  assign addr_valid = hsel && hready && smc_hready &&
                      ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  assign legal = cfg_enable && !(hwrite && cfg_wprot) && (hsize <= HSIZE_WORD);

  assign smc_busy = (state != AHB_IDLE); // Acceptance until ack has fallen

  // Byte lanes from size and low address bits
  always_comb begin
    case (hsize)
      HSIZE_BYTE: be_dec = 4'b0001 << haddr[1:0];
      HSIZE_HALF: be_dec = haddr[1] ? 4'b1100 : 4'b0011;
      default:    be_dec = 4'b1111;   // Word
    endcase
  end

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      state      <= AHB_IDLE;
      smc_hready <= 1'b1;
      smc_hresp  <= HRESP_OKAY;
      smc_valid  <= 1'b0;
      req        <= 1'b0;
      err_pulse  <= 1'b0;
    end else begin
      smc_valid <= addr_valid && legal;
      err_pulse <= addr_valid && !legal;  // Single count per error
      case (state)
        AHB_WAIT_DATA: begin
          state <= AHB_REQUEST;           // hwdata taken this edge
        end
        AHB_REQUEST: begin
          if (!req && !ack) begin
            req <= 1'b1;                  // Previous ack gone, start access
          end else if (req && ack) begin
            req        <= 1'b0;
            smc_hready <= 1'b1;           // Data phase ends
            state      <= AHB_COMPLETE;
          end
        end
        AHB_ERROR1: begin
          smc_hready <= 1'b1;             // Second error cycle
          state      <= AHB_ERROR2;
        end
        default: begin                    // Idle, complete, error2
          if (addr_valid) begin
            smc_hready <= 1'b0;
            if (legal) begin
              smc_hresp <= HRESP_OKAY;
              state     <= AHB_WAIT_DATA;
            end else begin
              smc_hresp <= HRESP_ERROR;   // Never reaches the device
              state     <= AHB_ERROR1;
            end
          end else begin
            smc_hready <= 1'b1;
            smc_hresp  <= HRESP_OKAY;
            state      <= AHB_IDLE;
          end
        end
      endcase
    end
  end

  // Access fields and read data
  always_ff @(posedge hclk) begin
    if (addr_valid) begin
      acc_addr  <= {haddr[31:2], 2'b00}; // Word aligned
      acc_write <= hwrite;
      acc_be    <= be_dec;
    end
    if (state == AHB_WAIT_DATA) begin
      acc_wdata <= hwdata;
    end
    if ((state == AHB_REQUEST) && req && ack) begin
      smc_hrdata <= rd_data;
    end
  end

endmodule

// ==== hdl/smc_cfg_regs.sv ====
/* Configuration registers of the memory controller on APB
   Enable, write protect, wait states and a saturating error counter */

module smc_cfg_regs
  import smc_pkg::*;
(
  input  logic        hclk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [4:0]  paddr,
  input  logic [31:0] pwdata,
  input  logic        err_pulse,   // One per error response
  output logic [31:0] prdata,
  output logic        cfg_enable,
  output logic        cfg_wprot,
  output logic [3:0]  cfg_rd_wait,
  output logic [3:0]  cfg_wr_wait
);

  logic [1:0]           ctrl_q;
  logic [ERR_CNT_W-1:0] err_cnt;
  logic                 apb_wr;

  assign apb_wr = psel && penable && pwrite; // Access phase commit

  assign cfg_enable = ctrl_q[0];
  assign cfg_wprot  = ctrl_q[1];

  // ----------------------------------------------------------------------
  // Register writes
  // ----------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      ctrl_q      <= CTRL_RESET;
      cfg_rd_wait <= RD_WAIT_RESET;
      cfg_wr_wait <= WR_WAIT_RESET;
    end else if (apb_wr) begin
      if (paddr == REG_CTRL) begin
        ctrl_q <= pwdata[1:0];
      end
      if (paddr == REG_TIMING) begin
        cfg_rd_wait <= pwdata[3:0];
        cfg_wr_wait <= pwdata[7:4];
      end
    end
  end

  // Error counter, write of any value clears
  always_ff @(posedge hclk) begin
    if (rst) begin
      err_cnt <= '0;
    end else if (apb_wr && (paddr == REG_STATUS)) begin
      err_cnt <= '0;                      // Clear beats a same-cycle error
    end else if (err_pulse && (err_cnt != {ERR_CNT_W{1'b1}})) begin
      err_cnt <= err_cnt + 1'b1;          // Sticks at max
    end
  end

  // Readback straight from the address
  always_comb begin
    case (paddr)
      REG_CTRL:   prdata = {30'd0, ctrl_q};
      REG_TIMING: prdata = {24'd0, cfg_wr_wait, cfg_rd_wait};
      REG_STATUS: prdata = {{(32-ERR_CNT_W){1'b0}}, err_cnt};
      default:    prdata = 32'd0;         // Unmapped
    endcase
  end

endmodule

// ==== hdl/smc_pkg.sv ====
/* Static memory controller shared definitions
   Bus codes, register map, reset values and FSM state codes */

package smc_pkg;

  // AHB transfer types
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // AHB sizes, anything above word is illegal here
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  localparam logic [1:0] HRESP_OKAY  = 2'b00;
  localparam logic [1:0] HRESP_ERROR = 2'b01;

  // ----------------------------------------------------------------------
  // APB register map
  // ----------------------------------------------------------------------
  localparam logic [4:0] REG_CTRL   = 5'h00; // [0] enable, [1] write protect
  localparam logic [4:0] REG_TIMING = 5'h04; // [3:0] rd wait, [7:4] wr wait
  localparam logic [4:0] REG_STATUS = 5'h08; // [15:0] error count

  localparam logic [1:0] CTRL_RESET    = 2'b01; // Enabled, unprotected
  localparam logic [3:0] RD_WAIT_RESET = 4'd2;
  localparam logic [3:0] WR_WAIT_RESET = 4'd1;
  localparam int         ERR_CNT_W     = 16;

  // Front end FSM states
  localparam logic [2:0] AHB_IDLE      = 3'd0;
  localparam logic [2:0] AHB_WAIT_DATA = 3'd1;
  localparam logic [2:0] AHB_REQUEST   = 3'd2;
  localparam logic [2:0] AHB_COMPLETE  = 3'd3;
  localparam logic [2:0] AHB_ERROR1    = 3'd4;
  localparam logic [2:0] AHB_ERROR2    = 3'd5;

  // Sequencer FSM states
  localparam logic [1:0] SEQ_IDLE   = 2'd0;
  localparam logic [1:0] SEQ_ACCESS = 2'd1;
  localparam logic [1:0] SEQ_ACK    = 2'd2;

endpackage
